// ==== filelist.f ====
aes_block_pkg.sv
aes_sbox_pkg.sv
aes_round_if.sv
sub_bytes.sv
shift_mix.sv
key_expand.sv
aes_control.sv
aes_datapath.sv
aes_core.sv
tb_clock.sv
tb_aes_assert.sv
tb_aes_core.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_aes_core -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_aes_core
if [ $? -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi

exit 0

// ==== tb_aes_core.sv ====
`timescale 1ns/1ps

module tb_aes_core
    import aes_block_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;   // 5 runs of at most 26 cycles plus reset

    // fips-197 vectors
    localparam block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam block_t C1_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam block_t C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
    localparam block_t B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    localparam block_t B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
    localparam block_t B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;
    localparam block_t Z_CT   = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

    logic   clk;
    logic   reset;
    logic   start;
    block_t plaintext;
    block_t key;
    block_t ciphertext;
    logic   done;
    logic   busy;

    block_t expected_ct;
    int     seed = 32'h0fd994c6;
    int     cycle_count = 0;

    tb_clock #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) i_tb_clock (
        .clk   (clk),
        .reset (reset)
    );

    aes_core #(
        .SBOX_BYTES_STATE (16),
        .SBOX_BYTES_KEY   (4)
    ) i_aes_core (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .plaintext  (plaintext),
        .key        (key),
        .ciphertext (ciphertext),
        .done       (done),
        .busy       (busy)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // checks and watchdogs
    // ~~~~~~~~~~~~~~~~~~~~

    ciphertext_check: assert property (@(posedge clk) disable iff (reset)
        done |-> ciphertext == expected_ct)
        else
        begin
            $display("FAILED ciphertext expected %h actual %h",
                $sampled(expected_ct), $sampled(ciphertext));
            $display("tests failed");
            $fatal(1, "wrong encryption result");
        end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk)
    begin
        if (i_aes_core.i_tb_aes_assert.error_count != 0)
        begin
            $display("a timing assertion on the core failed");
            $display("tests failed");
            $fatal(1, "timing assertion");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic block_t random_block();
        random_block = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic idle_gap();
        int gap;
        gap = $unsigned($random(seed)) % 6;   // 0 to 5 cycles
        repeat (gap) @(negedge clk);
    endtask

    // called on a falling edge while the core can accept
    task automatic launch_encryption(input block_t pt, input block_t k, input block_t exp);
        start     = 1'b1;
        plaintext = pt;
        key       = k;
        @(posedge clk);
        expected_ct <= exp;   // after the sampling edge
        @(negedge clk);
        start     = 1'b0;
        plaintext = random_block();   // unused until the next start
        key       = random_block();
    endtask

    task automatic pulse_start_while_busy();
        start     = 1'b1;
        plaintext = random_block();
        key       = random_block();
        @(negedge clk);
        start     = 1'b0;
    endtask

    // returns on the falling edge inside the done cycle
    task automatic wait_for_done();
        while (!done)
            @(negedge clk);
    endtask

    initial
    begin
        start       = 1'b0;
        plaintext   = '0;
        key         = '0;
        expected_ct = '0;
        @(negedge reset);
        @(negedge clk);

        idle_gap();
        launch_encryption(C1_PT, C1_KEY, C1_CT);
        wait_for_done();

        idle_gap();
        launch_encryption(B_PT, B_KEY, B_CT);
        repeat (6) @(negedge clk);
        pulse_start_while_busy();   // must be ignored
        wait_for_done();

        idle_gap();
        launch_encryption('0, '0, Z_CT);
        wait_for_done();

        // back to back, each start in the done cycle
        launch_encryption(C1_PT, C1_KEY, C1_CT);
        wait_for_done();
        launch_encryption(B_PT, B_KEY, B_CT);
        wait_for_done();

        repeat (3) @(negedge clk);
        if (i_aes_core.i_tb_aes_assert.error_count != 0)
        begin
            $display("a timing assertion on the core failed");
            $display("tests failed");
            $fatal(1, "timing assertion");
        end
        else
        begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== tb_aes_assert.sv ====
`timescale 1ns/1ps

module tb_aes_assert
    import aes_block_pkg::*;
(
    input logic   clk,
    input logic   reset,
    input logic   start,
    input logic   busy,
    input logic   done,
    input block_t ciphertext
);

    localparam int LATENCY = 20;   // edges from accepted start to done

    int error_count = 0;   // polled by the testbench top
    int since_accept;      // 0 when no run is being timed

    always @(posedge clk)
    begin
        if (reset)
            since_accept <= 0;
        else if (start && !busy)
            since_accept <= 1;
        else if (since_accept != 0 && since_accept <= LATENCY)
            since_accept <= since_accept + 1;
        else
            since_accept <= 0;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // protocol and timing
    // ~~~~~~~~~~~~~~~~~~~~

    reset_state: assert property (@(posedge clk)
        reset |=> !busy && !done && ciphertext == '0)
        else
        begin
            $error("core outputs not cleared by reset");
            error_count++;
        end

    // covers a start pulse seen while busy too
    running: assert property (@(posedge clk) disable iff (reset)
        (since_accept >= 1 && since_accept <= LATENCY) |-> busy && !done)
        else
        begin
            $error("busy dropped or done came early during a run");
            error_count++;
        end

    finishing: assert property (@(posedge clk) disable iff (reset)
        since_accept == LATENCY + 1 |-> done && !busy)
        else
        begin
            $error("done missing or busy still high at the end of a run");
            error_count++;
        end

    done_timing: assert property (@(posedge clk) disable iff (reset)
        done |-> since_accept == LATENCY + 1)
        else
        begin
            $error("done raised without a matching accepted start");
            error_count++;
        end

    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else
        begin
            $error("done stayed high for more than one cycle");
            error_count++;
        end

    // result only moves on completion
    result_hold: assert property (@(posedge clk) disable iff (reset)
        !done |-> $stable(ciphertext))
        else
        begin
            $error("ciphertext changed outside a completion");
            error_count++;
        end

endmodule

bind aes_core tb_aes_assert i_tb_aes_assert (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .ciphertext (ciphertext)
);

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released away from the sampling edge
    end

endmodule

// ==== aes_core.sv ====
`timescale 1ns/1ps

module aes_core
    import aes_block_pkg::*;
#(
    parameter int SBOX_BYTES_STATE = 16,
    parameter int SBOX_BYTES_KEY   = 4
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   start,
    input  block_t plaintext,
    input  block_t key,
    output block_t ciphertext,
    output logic   done,
    output logic   busy
);

    block_t round_key;

    aes_round_if rif ();

    aes_control i_aes_control (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .ctl   (rif.ctrl),
        .busy  (busy),
        .done  (done)
    );

    aes_datapath #(
        .SBOX_BYTES_STATE (SBOX_BYTES_STATE)
    ) i_aes_datapath (
        .clk        (clk),
        .reset      (reset),
        .plaintext  (plaintext),
        .round_key  (round_key),
        .key        (key),
        .rnd        (rif.round),
        .ciphertext (ciphertext)
    );

    key_expand #(
        .SBOX_BYTES_KEY (SBOX_BYTES_KEY)
    ) i_key_expand (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .rnd       (rif.round),
        .round_key (round_key)
    );

endmodule

// ==== aes_datapath.sv ====
`timescale 1ns/1ps

module aes_datapath
    import aes_block_pkg::*;
#(
    parameter int SBOX_BYTES_STATE = 16
) (
    input  logic              clk,
    input  logic              reset,
    input  block_t            plaintext,
    input  block_t            round_key,
    input  block_t            key,
    aes_round_if.round        rnd,
    output block_t            ciphertext
);

    block_t state_q;
    block_t sb_out;
    block_t sm_out;
    block_t next_state;
    block_t ct_q;

    // phase 0 result, read in phase 1
    sub_bytes #(
        .N (SBOX_BYTES_STATE)
    ) i_sub_bytes (
        .clk (clk),
        .p   (state_q),
        .o   (sb_out)
    );

    shift_mix i_shift_mix (
        .state_in  (sb_out),
        .last      (rnd.last),
        .state_out (sm_out)
    );

    assign next_state = sm_out ^ round_key;   // addroundkey

    always_ff @(posedge clk)
    begin
        if (rnd.load)
            state_q <= plaintext ^ key;   // initial addroundkey
        else if (rnd.step)
            state_q <= next_state;
    end

    // result held until the next completion
    always_ff @(posedge clk)
    begin
        if (reset)
            ct_q <= '0;
        else if (rnd.step && rnd.last)
            ct_q <= next_state;
    end

    assign ciphertext = ct_q;

endmodule

// ==== aes_control.sv ====
`timescale 1ns/1ps

module aes_control
    import aes_block_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    aes_round_if.ctrl   ctl,
    output logic        busy,
    output logic        done
);

    logic   busy_q;
    logic   done_q;
    logic   phase_q;
    round_t round_q;
    logic   accept;

    assign accept = start && !busy_q;   // start ignored while busy

    // ~~~~~~~~~~~~~~~~~~~~
    // round sequencer
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            phase_q <= 1'b0;
            round_q <= '0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                busy_q  <= 1'b1;
                phase_q <= 1'b0;
                round_q <= 4'd1;
            end
            else if (busy_q)
            begin
                phase_q <= !phase_q;
                if (phase_q)
                begin
                    if (round_q == NUM_ROUNDS)
                    begin
                        busy_q  <= 1'b0;   // last update edge
                        done_q  <= 1'b1;
                        round_q <= '0;
                    end
                    else
                        round_q <= round_q + 4'd1;
                end
            end
        end
    end

    assign ctl.load      = accept;
    assign ctl.phase     = phase_q;
    assign ctl.round_idx = round_q;
    assign ctl.last      = (round_q == NUM_ROUNDS);
    assign ctl.step      = busy_q && phase_q;

    assign busy = busy_q;
    assign done = done_q;

endmodule

// ==== key_expand.sv ====
`timescale 1ns/1ps

module key_expand
    import aes_block_pkg::*;
    import aes_sbox_pkg::*;
#(
    parameter int SBOX_BYTES_KEY = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  block_t            key,
    aes_round_if.round        rnd,
    output block_t            round_key
);

    block_t key_q;
    block_t src;
    block_t next_key;
    word_t  rot_w;
    word_t  sub_w;
    word_t  tmp_w;
    logic   advance;

    // the fresh cipher key goes straight in on load so that
    // round 1 already finds its substituted word waiting
    assign src   = rnd.load ? key : key_q;
    assign rot_w = {src[13], src[14], src[15], src[12]};   // rotword of w3

    sub_bytes #(
        .N (SBOX_BYTES_KEY)
    ) i_sub_bytes (
        .clk (clk),
        .p   (rot_w),
        .o   (sub_w)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // next round key
    // ~~~~~~~~~~~~~~~~~~~~

    assign tmp_w = sub_w ^ {rcon(rnd.round_idx), 24'h000000};

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            next_key[i]      = key_q[i] ^ tmp_w[i];
            next_key[4 + i]  = key_q[4 + i] ^ next_key[i];
            next_key[8 + i]  = key_q[8 + i] ^ next_key[4 + i];
            next_key[12 + i] = key_q[12 + i] ^ next_key[8 + i];
        end
    end

    // key moves on at the end of phase 0, ready for the step edge
    assign advance = !rnd.phase && (rnd.round_idx != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
            key_q <= '0;
        else if (rnd.load)
            key_q <= key;
        else if (advance)
            key_q <= next_key;
    end

    assign round_key = key_q;

endmodule

// ==== shift_mix.sv ====
`timescale 1ns/1ps

module shift_mix
    import aes_block_pkg::*;
(
    input  block_t state_in,
    input  logic   last,        // final round skips mixcolumns
    output block_t state_out
);

    block_t shifted;
    block_t mixed;
    word_t  col;

    // row r rotates left by r columns
    always_comb
    begin
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                shifted[4*c + r] = state_in[4*((c + r) % 4) + r];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // mixcolumns
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        col = '0;
        for (int c = 0; c < 4; c++)
        begin
            col = {shifted[4*c], shifted[4*c + 1], shifted[4*c + 2], shifted[4*c + 3]};
            mixed[4*c]     = gmul(col[0], 2'd2) ^ gmul(col[1], 2'd3) ^ col[2] ^ col[3];
            mixed[4*c + 1] = col[0] ^ gmul(col[1], 2'd2) ^ gmul(col[2], 2'd3) ^ col[3];
            mixed[4*c + 2] = col[0] ^ col[1] ^ gmul(col[2], 2'd2) ^ gmul(col[3], 2'd3);
            mixed[4*c + 3] = gmul(col[0], 2'd3) ^ col[1] ^ col[2] ^ gmul(col[3], 2'd2);
        end
    end

    assign state_out = last ? shifted : mixed;

endmodule

// ==== sub_bytes.sv ====
`timescale 1ns/1ps

module sub_bytes
    import aes_sbox_pkg::*;
#(
    parameter int N = 16   // bytes substituted per clock
) (
    input  logic                clk,
    input  logic [0:N-1][7:0]   p,
    output logic [0:N-1][7:0]   o
);

    // one s-box per byte, result registered
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < N; i++)
        begin
            o[i] <= sbox_lookup(p[i]);
        end
    end

endmodule

// ==== aes_round_if.sv ====
`timescale 1ns/1ps

// round sequencing shared by the data path and the key schedule
interface aes_round_if
    import aes_block_pkg::*;
();

    logic   load;        // accepted start, same cycle
    logic   phase;       // 0 substitute, 1 update
    round_t round_idx;   // current round, 0 when idle
    logic   last;        // round 10
    logic   step;        // phase 1 update strobe

    modport ctrl (
        output load,
        output phase,
        output round_idx,
        output last,
        output step
    );

    modport round (
        input load,
        input phase,
        input round_idx,
        input last,
        input step
    );

endinterface

// ==== aes_sbox_pkg.sv ====
package aes_sbox_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // forward s-box
    // ~~~~~~~~~~~~~~~~~~~~

    localparam logic [7:0] SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5, 8'h30, 8'h01, 8'h67, 8'h2b,
        8'hfe, 8'hd7, 8'hab, 8'h76, 8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0, 8'hb7, 8'hfd, 8'h93, 8'h26,
        8'h36, 8'h3f, 8'hf7, 8'hcc, 8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a, 8'h07, 8'h12, 8'h80, 8'he2,
        8'heb, 8'h27, 8'hb2, 8'h75, 8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84, 8'h53, 8'hd1, 8'h00, 8'hed,
        8'h20, 8'hfc, 8'hb1, 8'h5b, 8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85, 8'h45, 8'hf9, 8'h02, 8'h7f,
        8'h50, 8'h3c, 8'h9f, 8'ha8, 8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2, 8'hcd, 8'h0c, 8'h13, 8'hec,
        8'h5f, 8'h97, 8'h44, 8'h17, 8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88, 8'h46, 8'hee, 8'hb8, 8'h14,
        8'hde, 8'h5e, 8'h0b, 8'hdb, 8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79, 8'he7, 8'hc8, 8'h37, 8'h6d,
        8'h8d, 8'hd5, 8'h4e, 8'ha9, 8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6, 8'he8, 8'hdd, 8'h74, 8'h1f,
        8'h4b, 8'hbd, 8'h8b, 8'h8a, 8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e, 8'he1, 8'hf8, 8'h98, 8'h11,
        8'h69, 8'hd9, 8'h8e, 8'h94, 8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68, 8'h41, 8'h99, 8'h2d, 8'h0f,
        8'hb0, 8'h54, 8'hbb, 8'h16
    };

    function automatic logic [7:0] sbox_lookup(input logic [7:0] a);
        sbox_lookup = SBOX[a];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // key schedule constants
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] rcon(input logic [3:0] r);
        case (r)
            4'd1:    rcon = 8'h01;
            4'd2:    rcon = 8'h02;
            4'd3:    rcon = 8'h04;
            4'd4:    rcon = 8'h08;
            4'd5:    rcon = 8'h10;
            4'd6:    rcon = 8'h20;
            4'd7:    rcon = 8'h40;
            4'd8:    rcon = 8'h80;
            4'd9:    rcon = 8'h1b;
            4'd10:   rcon = 8'h36;
            default: rcon = 8'h00;   // round 0 has no constant
        endcase
    endfunction

endpackage

// ==== aes_block_pkg.sv ====
package aes_block_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // state and key types
    // ~~~~~~~~~~~~~~~~~~~~

    // byte 0 is the msb of the fips-197 input, byte index = row + 4*column
    typedef logic [0:15][7:0] block_t;

    typedef logic [0:3][7:0] word_t;   // one column or one key word

    typedef logic [3:0] round_t;       // 0 idle, 1..10 active

    localparam round_t NUM_ROUNDS = 4'd10;

    // ~~~~~~~~~~~~~~~~~~~~
    // gf(2^8) arithmetic
    // ~~~~~~~~~~~~~~~~~~~~

    // multiply by x, reduce with x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // small multiplier, only the mixcolumns constants 1, 2 and 3
    function automatic logic [7:0] gmul(input logic [7:0] b, input logic [1:0] m);
        case (m)
            2'd1:    gmul = b;
            2'd2:    gmul = xtime(b);
            2'd3:    gmul = xtime(b) ^ b;
            default: gmul = 8'h00;
        endcase
    endfunction

endpackage
